//--- verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

   // Datapath and register file geometry
   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;
   localparam int NUM_REGS   = 32;

   // Opcodes
   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_ADDI  = 6'h08;

   // R-format funct codes
   localparam logic [5:0] FN_ADD = 6'h20;
   localparam logic [5:0] FN_SUB = 6'h22;
   localparam logic [5:0] FN_AND = 6'h24;
   localparam logic [5:0] FN_OR  = 6'h25;
   localparam logic [5:0] FN_XOR = 6'h26;
   localparam logic [5:0] FN_SLT = 6'h2a;
   localparam logic [5:0] FN_MUL = 6'h18;

   // Same 32-bit word seen as R-format or as I-format
   typedef union packed {
      struct packed {
         logic [5:0]            opcode;
         logic [REG_ADDR_W-1:0] rs;
         logic [REG_ADDR_W-1:0] rt;
         logic [REG_ADDR_W-1:0] rd;
         logic [4:0]            shamt;
         logic [5:0]            funct;
      } r_fmt;
      struct packed {
         logic [5:0]            opcode;
         logic [REG_ADDR_W-1:0] rs;
         logic [REG_ADDR_W-1:0] rt;
         logic [15:0]           imm;
      } i_fmt;
   } instr_u;

endpackage

//--- verilog/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

   // ALU operation select
   localparam int ALU_OP_W = 3;

   localparam logic [ALU_OP_W-1:0] ALU_ADD = 3'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB = 3'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND = 3'd2;
   localparam logic [ALU_OP_W-1:0] ALU_OR  = 3'd3;
   localparam logic [ALU_OP_W-1:0] ALU_XOR = 3'd4;
   localparam logic [ALU_OP_W-1:0] ALU_SLT = 3'd5;

   // Multiplier depth, M1 to M5
   localparam int MULT_STAGES = 5;

   // Edges from acceptance to the register write
   localparam int ALU_WB_LAT  = 2;
   localparam int MULT_WB_LAT = MULT_STAGES + 1;

   // A multiply in this stage writes back on the same edge as an ALU op
   // issued now, so ALU issue has to wait one cycle
   localparam int MULT_SLOT_CLASH_STAGE = MULT_WB_LAT - ALU_WB_LAT - 1;

endpackage

//--- verilog/issue_if.sv
`timescale 1ns/1ns

interface issue_if;

   logic                                valid;     // Entry writes a register
   logic [cpu_isa_pkg::REG_ADDR_W-1:0]  dest;
   logic [cpu_isa_pkg::DATA_W-1:0]      src_data1;
   logic [cpu_isa_pkg::DATA_W-1:0]      src_data2;
   logic [cpu_isa_pkg::DATA_W-1:0]      imm;       // Already sign-extended
   logic [cpu_pipe_pkg::ALU_OP_W-1:0]   alu_op;
   logic                                alusrc;
   logic                                is_mult;

   modport decode (output valid, dest, src_data1, src_data2, imm, alu_op, alusrc, is_mult);

   modport alu (input valid, dest, src_data1, src_data2, imm, alu_op, alusrc, is_mult);

   modport mult (input valid, dest, src_data1, src_data2, is_mult);

   modport hazard (input valid, dest, is_mult);

endinterface

//--- verilog/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
   input  logic                                clk,
   input  logic                                id_ex_reset,
   input  cpu_isa_pkg::instr_u                 instr,
   input  logic                                instr_valid,
   input  logic                                stall,
   output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rs_addr,
   output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rt_addr,
   input  logic [cpu_isa_pkg::DATA_W-1:0]      rs_data,
   input  logic [cpu_isa_pkg::DATA_W-1:0]      rt_data,
   issue_if.decode                             issue
);

   logic [cpu_pipe_pkg::ALU_OP_W-1:0]   alu_op;
   logic                                alusrc;
   logic                                is_mult;
   logic                                reg_write;
   logic [cpu_isa_pkg::REG_ADDR_W-1:0]  dest;
   logic [cpu_isa_pkg::DATA_W-1:0]      imm_ext;
   logic                                accept;

   assign rs_addr = instr.r_fmt.rs;
   assign rt_addr = instr.r_fmt.rt;
   assign imm_ext = {{(cpu_isa_pkg::DATA_W-16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
   assign accept  = instr_valid && !stall;

   always_comb begin
      alu_op    = cpu_pipe_pkg::ALU_ADD;
      alusrc    = 1'b0;
      is_mult   = 1'b0;
      reg_write = 1'b0;
      dest      = instr.r_fmt.rd;
      case (instr.r_fmt.opcode)
         cpu_isa_pkg::OP_RTYPE: begin
            reg_write = 1'b1;
            case (instr.r_fmt.funct)
               cpu_isa_pkg::FN_ADD: alu_op = cpu_pipe_pkg::ALU_ADD;
               cpu_isa_pkg::FN_SUB: alu_op = cpu_pipe_pkg::ALU_SUB;
               cpu_isa_pkg::FN_AND: alu_op = cpu_pipe_pkg::ALU_AND;
               cpu_isa_pkg::FN_OR:  alu_op = cpu_pipe_pkg::ALU_OR;
               cpu_isa_pkg::FN_XOR: alu_op = cpu_pipe_pkg::ALU_XOR;
               cpu_isa_pkg::FN_SLT: alu_op = cpu_pipe_pkg::ALU_SLT;
               cpu_isa_pkg::FN_MUL: is_mult = 1'b1;
               default:             reg_write = 1'b0;   // Unknown funct
            endcase
         end
         cpu_isa_pkg::OP_ADDI: begin
            dest      = instr.i_fmt.rt;   // I-format writes rt
            alusrc    = 1'b1;
            reg_write = 1'b1;
         end
         default: reg_write = 1'b0;
      endcase
      // r0 is hardwired, never a destination
      if (dest == '0) begin
         reg_write = 1'b0;
      end
   end

   // Boundary register, bubble when nothing accepted
   always_ff @(posedge clk) begin
      if (id_ex_reset) begin
         issue.valid <= 1'b0;
      end else begin
         issue.valid <= accept && reg_write;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         issue.dest      <= dest;
         issue.src_data1 <= rs_data;
         issue.src_data2 <= rt_data;
         issue.imm       <= imm_ext;
         issue.alu_op    <= alu_op;
         issue.alusrc    <= alusrc;
         issue.is_mult   <= is_mult;
      end
   end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ns

module register_file (
   input  logic                                clk,
   input  logic                                id_ex_reset,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rs_addr,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rt_addr,
   output logic [cpu_isa_pkg::DATA_W-1:0]      rs_data,
   output logic [cpu_isa_pkg::DATA_W-1:0]      rt_data,
   input  logic                                alu_regwrite,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  alu_wreg,
   input  logic [cpu_isa_pkg::DATA_W-1:0]      alu_wdata,
   input  logic                                mul_regwrite,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  mul_wreg,
   input  logic [cpu_isa_pkg::DATA_W-1:0]      mul_wdata,
   output logic                                wb_regwrite,
   output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  wb_wreg,
   output logic [cpu_isa_pkg::DATA_W-1:0]      wb_wdata
);

   logic [cpu_isa_pkg::DATA_W-1:0] regs [cpu_isa_pkg::NUM_REGS];

   // Writeback merge, the two requests never overlap
   assign wb_regwrite = alu_regwrite || mul_regwrite;
   assign wb_wreg     = alu_regwrite ? alu_wreg : mul_wreg;
   assign wb_wdata    = alu_regwrite ? alu_wdata : mul_wdata;

   always_ff @(posedge clk) begin
      if (id_ex_reset) begin
         for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_regwrite && wb_wreg != '0) begin
         regs[wb_wreg] <= wb_wdata;
      end
   end

   // Asynchronous read ports
   assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

//--- verilog/hazard_control.sv
`timescale 1ns/1ns

module hazard_control (
   input  cpu_isa_pkg::instr_u                 instr,
   input  logic                                instr_valid,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rs_addr,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  rt_addr,
   issue_if.hazard                             issue,
   input  logic                                ex_valid,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  ex_dest,
   input  logic [cpu_pipe_pkg::MULT_STAGES-1:0] m_valid,
   input  logic [cpu_isa_pkg::REG_ADDR_W-1:0]  m_dest [cpu_pipe_pkg::MULT_STAGES],
   output logic                                stall
);

   logic                                new_is_mult;
   logic [cpu_isa_pkg::REG_ADDR_W-1:0]  new_dest;
   logic                                alu_hit;
   logic                                mul_hit;
   logic                                slot_clash;

   // Tag matches a source or the destination of the incoming word
   function automatic logic touches(
      input logic [cpu_isa_pkg::REG_ADDR_W-1:0] tag,
      input logic [cpu_isa_pkg::REG_ADDR_W-1:0] src1,
      input logic [cpu_isa_pkg::REG_ADDR_W-1:0] src2,
      input logic [cpu_isa_pkg::REG_ADDR_W-1:0] dst
   );
      return (tag == src1) || (tag == src2) || (tag == dst);
   endfunction

   always_comb begin
      new_is_mult = (instr.r_fmt.opcode == cpu_isa_pkg::OP_RTYPE) &&
                    (instr.r_fmt.funct == cpu_isa_pkg::FN_MUL);
      new_dest    = (instr.r_fmt.opcode == cpu_isa_pkg::OP_RTYPE) ? instr.r_fmt.rd
                                                                   : instr.i_fmt.rt;

      // Pending ALU results, boundary or execute/writeback
      alu_hit = (issue.valid && !issue.is_mult &&
                 touches(issue.dest, rs_addr, rt_addr, new_dest)) ||
                (ex_valid && touches(ex_dest, rs_addr, rt_addr, new_dest));

      // Pending multiply results, boundary then M1 to M5
      mul_hit = issue.valid && issue.is_mult &&
                touches(issue.dest, rs_addr, rt_addr, new_dest);
      for (int k = 0; k < cpu_pipe_pkg::MULT_STAGES; k++) begin
         mul_hit = mul_hit || (m_valid[k] && touches(m_dest[k], rs_addr, rt_addr, new_dest));
      end

      // Would share the writeback edge with that multiply
      slot_clash = !new_is_mult && m_valid[cpu_pipe_pkg::MULT_SLOT_CLASH_STAGE-1];

      stall = instr_valid && (alu_hit || mul_hit || slot_clash);
   end

endmodule

//--- verilog/exec_alu.sv
`timescale 1ns/1ns

module exec_alu (
   input  logic                                clk,
   input  logic                                id_ex_reset,
   issue_if.alu                                issue,
   output logic                                ex_valid,
   output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  ex_dest,
   output logic [cpu_isa_pkg::DATA_W-1:0]      alu_wdata
);

   logic [cpu_isa_pkg::DATA_W-1:0] op_b;
   logic [cpu_isa_pkg::DATA_W-1:0] result;
   logic                           alu_issue;

   assign alu_issue = issue.valid && !issue.is_mult;
   assign op_b      = issue.alusrc ? issue.imm : issue.src_data2;

   always_comb begin
      case (issue.alu_op)
         cpu_pipe_pkg::ALU_ADD: result = issue.src_data1 + op_b;
         cpu_pipe_pkg::ALU_SUB: result = issue.src_data1 - op_b;
         cpu_pipe_pkg::ALU_AND: result = issue.src_data1 & op_b;
         cpu_pipe_pkg::ALU_OR:  result = issue.src_data1 | op_b;
         cpu_pipe_pkg::ALU_XOR: result = issue.src_data1 ^ op_b;
         cpu_pipe_pkg::ALU_SLT: begin
            // Signed compare
            result = {{(cpu_isa_pkg::DATA_W-1){1'b0}},
                      ($signed(issue.src_data1) < $signed(op_b))};
         end
         default: result = '0;
      endcase
   end

   // Execute/writeback register
   always_ff @(posedge clk) begin
      if (id_ex_reset) begin
         ex_valid <= 1'b0;
      end else begin
         ex_valid <= alu_issue;
      end
   end

   always_ff @(posedge clk) begin
      if (alu_issue) begin
         ex_dest   <= issue.dest;
         alu_wdata <= result;
      end
   end

endmodule

//--- verilog/mult_pipe.sv
`timescale 1ns/1ns

module mult_pipe (
   input  logic                                 clk,
   input  logic                                 id_ex_reset,
   issue_if.mult                                issue,
   output logic [cpu_pipe_pkg::MULT_STAGES-1:0] m_valid,
   output logic [cpu_isa_pkg::REG_ADDR_W-1:0]   m_dest [cpu_pipe_pkg::MULT_STAGES],
   output logic [cpu_isa_pkg::DATA_W-1:0]       mul_wdata
);

   // M1 to M4 accumulate, M5 only holds the sum
   logic [cpu_isa_pkg::DATA_W-1:0] acc   [cpu_pipe_pkg::MULT_STAGES];
   logic [cpu_isa_pkg::DATA_W-1:0] op_a  [cpu_pipe_pkg::MULT_STAGES-2];   // Carried by M1..M3
   logic [cpu_isa_pkg::DATA_W-1:0] op_b  [cpu_pipe_pkg::MULT_STAGES-2];
   logic [cpu_isa_pkg::DATA_W-1:0] mac_a   [cpu_pipe_pkg::MULT_STAGES-1];
   logic [cpu_isa_pkg::DATA_W-1:0] mac_b   [cpu_pipe_pkg::MULT_STAGES-1];
   logic [cpu_isa_pkg::DATA_W-1:0] mac_acc [cpu_pipe_pkg::MULT_STAGES-1];
   logic [cpu_isa_pkg::DATA_W-1:0] pp      [cpu_pipe_pkg::MULT_STAGES-1];

   // Inputs of each accumulate stage
   always_comb begin
      mac_a[0]   = issue.src_data1;
      mac_b[0]   = issue.src_data2;
      mac_acc[0] = '0;
      for (int k = 1; k < cpu_pipe_pkg::MULT_STAGES - 1; k++) begin
         mac_a[k]   = op_a[k-1];
         mac_b[k]   = op_b[k-1];
         mac_acc[k] = acc[k-1];
      end
      // Stage k takes byte k of the second operand, already in place
      for (int k = 0; k < cpu_pipe_pkg::MULT_STAGES - 1; k++) begin
         pp[k] = mac_a[k] *
                 (mac_b[k] & ({{(cpu_isa_pkg::DATA_W-8){1'b0}}, 8'hff} << (8 * k)));
      end
   end

   // Tag shift, new entry enters at M1
   always_ff @(posedge clk) begin
      if (id_ex_reset) begin
         m_valid <= '0;
      end else begin
         m_valid <= {m_valid[cpu_pipe_pkg::MULT_STAGES-2:0], issue.valid && issue.is_mult};
      end
   end

   always_ff @(posedge clk) begin
      m_dest[0] <= issue.dest;
      for (int k = 1; k < cpu_pipe_pkg::MULT_STAGES; k++) begin
         m_dest[k] <= m_dest[k-1];
      end
      for (int k = 0; k < cpu_pipe_pkg::MULT_STAGES - 1; k++) begin
         acc[k] <= mac_acc[k] + pp[k];
      end
      acc[cpu_pipe_pkg::MULT_STAGES-1] <= acc[cpu_pipe_pkg::MULT_STAGES-2];
      for (int k = 0; k < cpu_pipe_pkg::MULT_STAGES - 2; k++) begin
         op_a[k] <= mac_a[k];
         op_b[k] <= mac_b[k];
      end
   end

   assign mul_wdata = acc[cpu_pipe_pkg::MULT_STAGES-1];   // Low 32 bits of the product

endmodule

//--- verilog/mini_cpu_top.sv
`timescale 1ns/1ns

module mini_cpu_top (
   input  logic                                clk,
   input  logic                                id_ex_reset,
   input  logic [cpu_isa_pkg::DATA_W-1:0]      instr,
   input  logic                                instr_valid,
   output logic                                stall,
   output logic                                wb_regwrite,
   output logic [cpu_isa_pkg::REG_ADDR_W-1:0]  wb_wreg,
   output logic [cpu_isa_pkg::DATA_W-1:0]      wb_wdata
);

   logic [cpu_isa_pkg::REG_ADDR_W-1:0]   rs_addr;
   logic [cpu_isa_pkg::REG_ADDR_W-1:0]   rt_addr;
   logic [cpu_isa_pkg::DATA_W-1:0]       rs_data;
   logic [cpu_isa_pkg::DATA_W-1:0]       rt_data;
   logic                                 ex_valid;
   logic [cpu_isa_pkg::REG_ADDR_W-1:0]   ex_dest;
   logic [cpu_isa_pkg::DATA_W-1:0]       alu_wdata;
   logic [cpu_pipe_pkg::MULT_STAGES-1:0] m_valid;
   logic [cpu_isa_pkg::REG_ADDR_W-1:0]   m_dest [cpu_pipe_pkg::MULT_STAGES];
   logic [cpu_isa_pkg::DATA_W-1:0]       mul_wdata;

   issue_if issue ();   // Decode/execute boundary

   decode_unit decode_unit_inst (
      .clk         (clk),
      .id_ex_reset (id_ex_reset),
      .instr       (instr),
      .instr_valid (instr_valid),
      .stall       (stall),
      .rs_addr     (rs_addr),
      .rt_addr     (rt_addr),
      .rs_data     (rs_data),
      .rt_data     (rt_data),
      .issue       (issue.decode)
   );

   register_file register_file_inst (
      .clk          (clk),
      .id_ex_reset  (id_ex_reset),
      .rs_addr      (rs_addr),
      .rt_addr      (rt_addr),
      .rs_data      (rs_data),
      .rt_data      (rt_data),
      .alu_regwrite (ex_valid),
      .alu_wreg     (ex_dest),
      .alu_wdata    (alu_wdata),
      .mul_regwrite (m_valid[cpu_pipe_pkg::MULT_STAGES-1]),   // M5 request
      .mul_wreg     (m_dest[cpu_pipe_pkg::MULT_STAGES-1]),
      .mul_wdata    (mul_wdata),
      .wb_regwrite  (wb_regwrite),
      .wb_wreg      (wb_wreg),
      .wb_wdata     (wb_wdata)
   );

   hazard_control hazard_control_inst (
      .instr       (instr),
      .instr_valid (instr_valid),
      .rs_addr     (rs_addr),
      .rt_addr     (rt_addr),
      .issue       (issue.hazard),
      .ex_valid    (ex_valid),
      .ex_dest     (ex_dest),
      .m_valid     (m_valid),
      .m_dest      (m_dest),
      .stall       (stall)
   );

   exec_alu exec_alu_inst (
      .clk         (clk),
      .id_ex_reset (id_ex_reset),
      .issue       (issue.alu),
      .ex_valid    (ex_valid),
      .ex_dest     (ex_dest),
      .alu_wdata   (alu_wdata)
   );

   mult_pipe mult_pipe_inst (
      .clk         (clk),
      .id_ex_reset (id_ex_reset),
      .issue       (issue.mult),
      .m_valid     (m_valid),
      .m_dest      (m_dest),
      .mul_wdata   (mul_wdata)
   );

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic clk
);

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ns

module tb_top;

   localparam int RESET_CYCLES = 5;
   localparam int DRAIN_CYCLES = 10;
   localparam int NUM_TESTS    = 6;
   localparam int TOTAL_INSTR  = 40 + 30 + 30 + 24 + 80 + 20;
   localparam int TIMEOUT_CYCLES = TOTAL_INSTR * 8 + NUM_TESTS * DRAIN_CYCLES + RESET_CYCLES;

   logic        clk;
   logic        id_ex_reset;
   logic [31:0] instr;
   logic        instr_valid;
   logic        stall;
   logic        wb_regwrite;
   logic [4:0]  wb_wreg;
   logic [31:0] wb_wdata;

   integer      seed = 32'h9254df8f;
   logic [31:0] model_regs [32];
   logic [36:0] pend_q [$];    // {dest, value} in program order
   logic [31:0] prog_q [$];
   string       test_name = "reset";
   int          error_count = 0;
   int          check_count = 0;
   int          tests_failed = 0;
   int          cycle_count = 0;

   tb_clock tb_clock_inst (.clk(clk));

   mini_cpu_top mini_cpu_top_inst (
      .clk         (clk),
      .id_ex_reset (id_ex_reset),
      .instr       (instr),
      .instr_valid (instr_valid),
      .stall       (stall),
      .wb_regwrite (wb_regwrite),
      .wb_wreg     (wb_wreg),
      .wb_wdata    (wb_wdata)
   );

   function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [5:0] fn);
      return {cpu_isa_pkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [4:0] pick_reg(input logic [31:0] r);
      return 5'(1 + r % 31);   // Never r0
   endfunction

   function automatic logic [5:0] alu_funct(input logic [31:0] r);
      case (r % 6)
         0: return cpu_isa_pkg::FN_ADD;
         1: return cpu_isa_pkg::FN_SUB;
         2: return cpu_isa_pkg::FN_AND;
         3: return cpu_isa_pkg::FN_OR;
         4: return cpu_isa_pkg::FN_XOR;
         default: return cpu_isa_pkg::FN_SLT;
      endcase
   endfunction

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("CHECK FAILED test=%s expected=%h actual=%h", name, expected, actual);
      end
   endtask

   // Executes one accepted word on the model register file
   task automatic model_exec(input logic [31:0] word);
      logic [5:0]  op;
      logic [5:0]  fn;
      logic [4:0]  dest;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] res;
      logic        writes;
      op     = word[31:26];
      fn     = word[5:0];
      a      = model_regs[word[25:21]];
      b      = model_regs[word[20:16]];
      dest   = word[15:11];
      res    = '0;
      writes = 1'b1;
      if (op == cpu_isa_pkg::OP_ADDI) begin
         dest = word[20:16];   // I-format target is rt
         res  = a + {{16{word[15]}}, word[15:0]};
      end else if (op == cpu_isa_pkg::OP_RTYPE) begin
         case (fn)
            cpu_isa_pkg::FN_ADD: res = a + b;
            cpu_isa_pkg::FN_SUB: res = a - b;
            cpu_isa_pkg::FN_AND: res = a & b;
            cpu_isa_pkg::FN_OR:  res = a | b;
            cpu_isa_pkg::FN_XOR: res = a ^ b;
            cpu_isa_pkg::FN_SLT: res = {31'd0, $signed(a) < $signed(b)};
            cpu_isa_pkg::FN_MUL: res = a * b;
            default:             writes = 1'b0;
         endcase
      end else begin
         writes = 1'b0;
      end
      if (writes && dest != 5'd0) begin
         model_regs[dest] = res;
         pend_q.push_back({dest, res});
      end
   endtask

   // Holds the word until an edge with stall low takes it
   task automatic issue_word(input logic [31:0] word);
      logic accepted;
      instr       = word;
      instr_valid = 1'b1;
      accepted    = 1'b0;
      while (!accepted) begin
         @(negedge clk);
         accepted = !stall;
         @(posedge clk);
         #1;
         if (accepted) begin
            model_exec(word);
         end
      end
   endtask

   task automatic run_program(input string name, input bit gaps);
      int          errs_before;
      logic [31:0] word;
      logic [36:0] entry;
      errs_before = error_count;
      test_name   = name;
      while (prog_q.size() > 0) begin
         word = prog_q.pop_front();
         if (gaps && ($unsigned($random(seed)) % 8 == 0)) begin
            instr_valid = 1'b0;   // Bubble
            @(posedge clk);
            #1;
         end
         issue_word(word);
      end
      instr_valid = 1'b0;
      repeat (DRAIN_CYCLES) @(posedge clk);
      #1;
      while (pend_q.size() > 0) begin
         entry = pend_q.pop_front();
         error_count++;
         $display("Test %s: expected write of %h to r%0d never happened",
                  name, entry[31:0], entry[36:32]);
      end
      if (error_count == errs_before) begin
         $display("Test %-10s done, ok", name);
      end else begin
         tests_failed++;
         $display("Test %-10s done, %0d errors", name, error_count - errs_before);
      end
   endtask

   // Oldest pending write to the same register
   task automatic check_writeback();
      int idx;
      idx = -1;
      for (int i = 0; i < pend_q.size(); i++) begin
         if (idx < 0 && pend_q[i][36:32] == wb_wreg) idx = i;
      end
      if (idx < 0) begin
         error_count++;
         $display("Test %s: writeback of %h to r%0d was not expected",
                  test_name, wb_wdata, wb_wreg);
      end else begin
         compare_value(test_name, pend_q[idx][31:0], wb_wdata);
         pend_q.delete(idx);
      end
   endtask

   always @(negedge clk) begin
      if (!id_ex_reset && wb_regwrite) check_writeback();
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   initial begin
      logic [4:0]  d;
      logic [4:0]  nd;
      logic [15:0] imm;
      logic [5:0]  op;
      instr       = '0;
      instr_valid = 1'b0;
      id_ex_reset = 1'b1;
      for (int i = 0; i < 32; i++) model_regs[i] = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 id_ex_reset = 1'b0;
      // Valid word with nothing in flight, writes r0 so it leaves no trace
      instr       = r_word(5'd1, 5'd2, 5'd0, cpu_isa_pkg::FN_ADD);
      instr_valid = 1'b1;
      @(negedge clk);
      compare_value("reset", 32'd0, {30'd0, stall, wb_regwrite});
      @(posedge clk);
      #1 instr_valid = 1'b0;

      for (int i = 0; i < 8; i++) begin   // Seed values first
         prog_q.push_back(i_word(cpu_isa_pkg::OP_ADDI, 5'd0, 5'(i + 1), 16'($random(seed))));
      end
      for (int i = 0; i < 32; i++) begin
         prog_q.push_back(r_word(pick_reg($random(seed)), pick_reg($random(seed)),
                                 pick_reg($random(seed)), alu_funct($random(seed))));
      end
      run_program("rtype", 1'b1);

      for (int i = 0; i < 30; i++) begin
         imm = 16'($random(seed));
         if (i % 2 == 1) imm[15] = 1'b1;   // Negative immediate
         prog_q.push_back(i_word(cpu_isa_pkg::OP_ADDI, pick_reg($random(seed)),
                                 pick_reg($random(seed)), imm));
      end
      run_program("addi", 1'b1);

      for (int i = 0; i < 30; i++) begin
         prog_q.push_back(r_word(pick_reg($random(seed)), pick_reg($random(seed)),
                                 pick_reg($random(seed)), cpu_isa_pkg::FN_MUL));
      end
      run_program("mul", 1'b1);

      d = pick_reg($random(seed));
      for (int i = 0; i < 24; i++) begin
         nd = pick_reg($random(seed));
         if (i % 3 == 0) begin
            prog_q.push_back(r_word(d, pick_reg($random(seed)), nd, cpu_isa_pkg::FN_MUL));
         end else begin
            prog_q.push_back(r_word(d, pick_reg($random(seed)), nd, alu_funct($random(seed))));
         end
         d = nd;   // Next one reads this result
      end
      run_program("chain", 1'b0);

      for (int i = 0; i < 80; i++) begin
         d = 5'(1 + $unsigned($random(seed)) % 4);   // Few targets, many WAW pairs
         if ($random(seed) & 1) begin
            prog_q.push_back(r_word(5'(1 + $unsigned($random(seed)) % 8),
                                    5'(1 + $unsigned($random(seed)) % 8), d,
                                    cpu_isa_pkg::FN_MUL));
         end else if ($unsigned($random(seed)) % 4 == 0) begin
            prog_q.push_back(i_word(cpu_isa_pkg::OP_ADDI, 5'(1 + $unsigned($random(seed)) % 8),
                                    d, 16'($random(seed))));
         end else begin
            prog_q.push_back(r_word(5'(1 + $unsigned($random(seed)) % 8),
                                    5'(1 + $unsigned($random(seed)) % 8), d,
                                    alu_funct($random(seed))));
         end
      end
      run_program("mixed", 1'b0);

      for (int i = 0; i < 20; i++) begin
         op = 6'($random(seed));
         if (op == cpu_isa_pkg::OP_RTYPE || op == cpu_isa_pkg::OP_ADDI) op = 6'h3f;
         case (i % 5)
            0: prog_q.push_back(r_word(pick_reg($random(seed)), pick_reg($random(seed)),
                                       5'd0, alu_funct($random(seed))));
            1: prog_q.push_back(i_word(cpu_isa_pkg::OP_ADDI, pick_reg($random(seed)),
                                       5'd0, 16'($random(seed))));
            2: prog_q.push_back({op, 26'($random(seed))});   // Unknown opcode
            3: prog_q.push_back(r_word(pick_reg($random(seed)), pick_reg($random(seed)),
                                       pick_reg($random(seed)), 6'h01));
            default: prog_q.push_back(r_word(5'd0, 5'd0, pick_reg($random(seed)),
                                             cpu_isa_pkg::FN_OR));
         endcase
      end
      run_program("r0_unknown", 1'b1);

      $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
               NUM_TESTS, tests_failed, check_count, error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- build.f
verilog/cpu_isa_pkg.sv
verilog/cpu_pipe_pkg.sv
verilog/issue_if.sv
verilog/decode_unit.sv
verilog/register_file.sv
verilog/hazard_control.sv
verilog/exec_alu.sv
verilog/mult_pipe.sv
verilog/mini_cpu_top.sv
verif/tb_clock.sv
verif/tb_top.sv
